// File: sources.f
common/tilemap_pkg.sv
source/dual_port_ram.sv
source/palette_prom.sv
source/video_timing.sv
scroll/scroll_layer.sv
source/tilemap_top.sv
sim/tile_rom_model.sv
sim/tb_tilemap.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the tile map testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f sources.f \
    --top-module tb_tilemap \
    -o tb_tilemap

./obj_dir/tb_tilemap > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST PASSED" sim.log; then
    exit 0
else
    exit 1
fi

// File: sim/tb_tilemap.sv
// Testbench for the tile map subsystem
// Checks VRAM access, reset state and every visible pixel
// against a reference model of the layer

`timescale 1ns/10ps

module tb_tilemap import tilemap_pkg::*;;

    typedef struct packed {
        logic       flip;
        logic       hyper;
        logic [7:0] hpos;
        logic [7:0] lines;
    } case_t;

    localparam int n_cases = 5;
    localparam case_t cases [0:n_cases-1] = '{
        '{1'b0, 1'b0, 8'h00, 8'd3},
        '{1'b0, 1'b0, 8'h35, 8'd3},    // Odd scroll, bit 0 is dropped
        '{1'b0, 1'b1, 8'h82, 8'd3},
        '{1'b1, 1'b0, 8'h00, 8'd3},
        '{1'b1, 1'b1, 8'h57, 8'd3}
    };

    logic              clk;
    logic              rst;
    cpu_bus_t          cpu;
    logic [7:0]        vram_dout;
    logic [7:0]        scr_din;
    logic              scr_we;
    logic              flip;
    logic              is_hyper;
    logic [3:0]        prog_data;
    logic [7:0]        prog_addr;
    logic              prog_en;
    logic [rom_aw-1:0] rom_addr;
    logic [31:0]       rom_data;
    beam_t             beam;
    logic              pxl_cen;
    logic [3:0]        pxl;

    logic [7:0] vram_code [0:2**vram_aw-1];
    logic [7:0] vram_attr [0:2**vram_aw-1];
    logic [3:0] prom      [0:255];
    int         pix_err;
    int         byte_err;
    int         addr_err;

    tilemap_top #(.pxl_div(8), .vram_aw(vram_aw)) u_dut (
        .clk(clk), .rst(rst), .cpu(cpu), .vram_dout(vram_dout),
        .scr_din(scr_din), .scr_we(scr_we), .flip(flip), .is_hyper(is_hyper),
        .prog_data(prog_data), .prog_addr(prog_addr), .prog_en(prog_en),
        .rom_addr(rom_addr), .rom_data(rom_data), .beam(beam),
        .pxl_cen(pxl_cen), .pxl(pxl)
    );

    tile_rom_model u_rom (.clk(clk), .addr(rom_addr), .data(rom_data));

    function automatic logic [31:0] rom_word(input logic [13:0] a);
        return {a, 2'b01, ~a, 2'b10} ^ (32'(a) * 32'h9e37_79b1);
    endfunction

    // Pixel n of a ROM word, four planes of 4 bits per 16-bit half
    function automatic logic [3:0] rom_nibble(input logic [31:0] d, input int n);
        int p;
        p = 16 * (n / 4) + n % 4;
        return {d[p+8], d[p+12], d[p], d[p+4]};
    endfunction

    function automatic logic [3:0] model_pixel(input logic [8:0] col,
                                               input logic [7:0] row,
                                               input logic hyper);
        logic [10:0]    idx;
        tile_attr_u     a;
        logic [2:0]     ext;
        logic [13:0]    ra;
        int             nib;
        pal_prom_addr_t pa;
        idx = {row[7:3], col[8:3]};
        a   = vram_attr[idx];
        ext = {a.n.code_hi, a.n.code_top};
        if (hyper) ext[1] = 1'b0;   // Attribute bit 5 never reaches the ROM
        ra  = {ext, vram_code[idx], row[2:0]};
        nib = a.n.hflip ? int'(col[2:0]) : 7 - int'(col[2:0]);
        pa.pal = a.n.pal;
        pa.pix = rom_nibble(rom_word(ra), nib);
        return prom[pa];
    endfunction

    task automatic check_byte(input string name, input logic [7:0] got,
                              input logic [7:0] exp);
        if (got !== exp) begin
            byte_err++;
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_pixel(input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            pix_err++;
            $display("mismatch at %0t: pxl got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_addr(input logic [rom_aw-1:0] got, input logic [rom_aw-1:0] exp);
        if (got !== exp) begin
            addr_err++;
            $display("mismatch at %0t: rom_addr got %h expected %h", $time, got, exp);
        end
    endtask

    // Negedge with the strobe pending, outputs of the previous strobe are settled
    task automatic wait_strobe();
        do @(negedge clk); while (!pxl_cen);
    endtask

    task automatic vram_write(input logic bank, input logic [10:0] a, input logic [7:0] d);
        @(posedge clk);
        cpu <= '{addr: {bank, a}, wdata: d, rnw: 1'b0, cs: 1'b1};
        @(posedge clk);
        cpu <= '0;
        if (bank) vram_attr[a] = d;
        else vram_code[a] = d;
    endtask

    task automatic vram_read_check(input logic bank, input logic [10:0] a);
        @(posedge clk);
        cpu <= '{addr: {bank, a}, wdata: 8'h00, rnw: 1'b1, cs: 1'b1};
        @(posedge clk);
        cpu <= '0;
        @(negedge clk);
        check_byte("vram_dout", vram_dout, bank ? vram_attr[a] : vram_code[a]);
    endtask

    task automatic pulse_reset();
        rst <= 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Watchdog sized from the table, two spare lines per case
    initial begin
        longint limit;
        limit = 500_000;
        for (int i = 0; i < n_cases; i++) begin
            limit += (longint'(cases[i].lines) + 2) * 384 * 8 * 4;
        end
        #(limit);
        $display("timeout: the run did not finish in %0d ns", limit);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        logic [31:0] r;
        logic [8:0]  hd;
        logic [8:0]  col;
        logic [7:0]  row;
        int          n;
        rst = 1'b1;
        cpu = '0;
        scr_din = '0;
        scr_we = 1'b0;
        flip = 1'b0;
        is_hyper = 1'b0;
        prog_data = '0;
        prog_addr = '0;
        prog_en = 1'b0;
        pix_err = 0;
        byte_err = 0;
        addr_err = 0;
        row = '0;
        r = $urandom(32'h4d08_b33f);
        pulse_reset();

        for (int i = 0; i < 256; i++) begin
            @(posedge clk);
            r = $urandom();
            prog_addr <= 8'(i);
            prog_data <= r[3:0];
            prog_en   <= 1'b1;
            prom[i] = r[3:0];
        end
        @(posedge clk);
        prog_en <= 1'b0;

        // Fresh reset with the palette loaded
        pulse_reset();
        check_addr(rom_addr, '0);
        wait_strobe();
        wait_strobe();
        check_pixel(pxl, prom[0]);
        check_addr(rom_addr, '0);

        for (int i = 0; i < 2**vram_aw; i++) begin
            r = $urandom();
            vram_write(1'b0, 11'(i), r[7:0]);
            vram_write(1'b1, 11'(i), r[15:8]);
        end
        for (int i = 0; i < 64; i++) begin
            r = $urandom();
            vram_write(r[11], r[10:0], r[19:12]);
            vram_read_check(r[11], r[10:0]);
            vram_read_check(~r[11], r[10:0]);     // Other bank untouched
        end

        for (int c = 0; c < n_cases; c++) begin
            do begin
                wait_strobe();
                hd = beam.hdump;
            end while (hd != 9'd300);   // Change settings in blank
            @(posedge clk);
            flip     <= cases[c].flip;
            is_hyper <= cases[c].hyper;
            scr_din  <= cases[c].hpos;
            scr_we   <= 1'b1;
            @(posedge clk);
            scr_we   <= 1'b0;
            do begin
                wait_strobe();
                hd = beam.hdump;
            end while (hd != 9'd0);
            n = 0;
            while (n < int'(cases[c].lines)) begin
                wait_strobe();
                hd = beam.hdump;
                if (hd == 9'd1) row = beam.vdump;
                if (hd >= 9'd1 && hd <= 9'd256) begin
                    // Pixel of the strobe at hdump hd - 1
                    col = hd - 9'd1 + {cases[c].hpos[7:1], 1'b0};
                    check_pixel(pxl, model_pixel(col ^ {1'b0, {8{cases[c].flip}}},
                                                 row ^ {8{cases[c].flip}},
                                                 cases[c].hyper));
                end
                if (hd == 9'd256) n++;
            end
        end

        $display("errors: pixel %0d, byte %0d, address %0d", pix_err, byte_err, addr_err);
        if (pix_err + byte_err + addr_err == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: sim/tile_rom_model.sv
// Graphics ROM model
// 16K words of 32 bits from a fixed hash of the address,
// data appears two clocks after the address

`timescale 1ns/10ps

module tile_rom_model (
    input  logic        clk,
    input  logic [13:0] addr,
    output logic [31:0] data
);

    logic [13:0] addr_d;

    // Every address bit reaches the upper and lower halves
    function automatic logic [31:0] rom_hash(input logic [13:0] a);
        return {a, 2'b01, ~a, 2'b10} ^ (32'(a) * 32'h9e37_79b1);
    endfunction

    always_ff @(posedge clk) begin
        addr_d <= addr;
        data   <= rom_hash(addr_d);     // Second stage of latency
    end

endmodule

// File: source/tilemap_top.sv
// Tile map subsystem top level
// Timing generator driving the scrolling layer

`timescale 1ns/10ps

module tilemap_top import tilemap_pkg::*; #(
    parameter int pxl_div = 8,
    parameter int vram_aw = tilemap_pkg::vram_aw
)(
    input  logic              clk,
    input  logic              rst,
    // CPU
    input  cpu_bus_t          cpu,
    output logic [7:0]        vram_dout,
    input  logic [7:0]        scr_din,
    input  logic              scr_we,
    // Board configuration
    input  logic              flip,
    input  logic              is_hyper,
    // Palette load
    input  logic [3:0]        prog_data,
    input  logic [7:0]        prog_addr,
    input  logic              prog_en,
    // Graphics ROM
    output logic [rom_aw-1:0] rom_addr,
    input  logic [31:0]       rom_data,
    // Video
    output beam_t             beam,
    output logic              pxl_cen,
    output logic [3:0]        pxl
);

    video_timing #(.pxl_div(pxl_div)) u_timing (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .beam    (beam)
    );

    scroll_layer #(.aw(vram_aw)) u_scroll (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .beam      (beam),
        .flip      (flip),
        .is_hyper  (is_hyper),
        .cpu       (cpu),
        .vram_dout (vram_dout),
        .scr_din   (scr_din),
        .scr_we    (scr_we),
        .prog_data (prog_data),
        .prog_addr (prog_addr),
        .prog_en   (prog_en),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .pxl       (pxl)
    );

endmodule

// File: scroll/scroll_layer.sv
// Scrolling background layer
// Code and attribute VRAM, per-tile fetch from the graphics ROM,
// bit reorder into 4-bit pixels, shifter and palette lookup

`timescale 1ns/10ps

module scroll_layer import tilemap_pkg::*; #(
    parameter int aw = vram_aw
)(
    input  logic              clk,
    input  logic              rst,
    input  logic              pxl_cen,
    input  beam_t             beam,
    input  logic              flip,
    input  logic              is_hyper,
    // CPU side
    input  cpu_bus_t          cpu,
    output logic [7:0]        vram_dout,
    input  logic [7:0]        scr_din,
    input  logic              scr_we,
    // Palette load
    input  logic [3:0]        prog_data,
    input  logic [7:0]        prog_addr,
    input  logic              prog_en,
    // Graphics ROM
    output logic [rom_aw-1:0] rom_addr,
    input  logic [31:0]       rom_data,
    output logic [3:0]        pxl
);

    // Registered palette output at hdump h shows column h plus scroll.
    // One less under flip as the fetch order within a tile reverses
    localparam logic [8:0] col_lead = 9'd13;

    logic [7:0]     code;
    logic [7:0]     code_cpu;
    logic [7:0]     attr_cpu;
    tile_attr_u     attr;
    logic           we_code;
    logic           we_attr;
    logic           rd_sel;
    logic [aw-1:0]  rd_addr;
    logic [7:0]     hpos;
    logic [7:0]     vf;
    logic [8:0]     hcol;
    logic [8:0]     heff;
    logic [2:0]     code_ext;
    logic [3:0]     nxt_pal;
    logic           nxt_hf;
    logic [3:0]     cur_pal;
    logic           cur_hf;
    logic [31:0]    pxl_data;
    pal_prom_addr_t pal_addr;

    // ROM planes are interleaved, gather each pixel's four bits
    function automatic logic [31:0] unscramble(input logic [31:0] d);
        logic [31:0] p;
        int          base;
        p = '0;
        for (int n = 0; n < 8; n++) begin
            base = 16 * (n / 4) + n % 4;
            p[4*n +: 4] = {d[base+8], d[base+12], d[base], d[base+4]};
        end
        return p;
    endfunction

    assign we_code   = cpu.cs & ~cpu.rnw & ~cpu.addr[11];
    assign we_attr   = cpu.cs & ~cpu.rnw &  cpu.addr[11];
    assign vram_dout = rd_sel ? attr_cpu : code_cpu;

    always_comb begin
        // In blank the column runs on to meet column 0 of the next line
        hcol = beam.lhbl ? beam.hdump : {2'b11, beam.hdump[6:0]};
        heff = (hcol + {1'b0, hpos[7:1], 1'b0} + col_lead - 9'(flip))
               ^ {1'b0, {8{flip}}};
        code_ext = is_hyper ? {attr.h.ext, 1'b0, attr.h.code_top}
                            : {attr.n.code_hi, attr.n.code_top};
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hpos   <= '0;
            vf     <= '0;
            rd_sel <= 1'b0;
        end else begin
            if (scr_we) begin
                hpos <= scr_din;
            end
            vf <= beam.vdump ^ {8{flip}};
            if (cpu.cs && cpu.rnw) begin
                rd_sel <= cpu.addr[11];     // Bank for the read data next clock
            end
        end
    end

    // Tile address and attribute of the tile being fetched
    always_ff @(posedge clk) begin
        if (pxl_cen && heff[2:0] == 3'd7) begin
            rd_addr <= aw'({vf[7:3], heff[8:3]});
        end
        if (pxl_cen && heff[2:0] == 3'd0) begin
            nxt_pal <= attr.n.pal;
            nxt_hf  <= attr.n.hflip ^ flip;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_addr <= '0;
            pxl_data <= '0;
            cur_pal  <= '0;
            cur_hf   <= 1'b0;
        end else if (pxl_cen) begin
            if (heff[2:0] == 3'd0) begin
                rom_addr <= {code_ext, code, vf[2:0]};
            end
            if (heff[2:0] == 3'd4) begin   // ROM has had four pixels to answer
                pxl_data <= unscramble(rom_data);
                cur_pal  <= nxt_pal;
                cur_hf   <= nxt_hf;
            end else begin
                pxl_data <= cur_hf ? pxl_data >> 4 : pxl_data << 4;
            end
        end
    end

    assign pal_addr = {cur_pal, cur_hf ? pxl_data[3:0] : pxl_data[31:28]};

    dual_port_ram #(.aw(aw), .dw(8)) u_code (
        .clk   (clk),
        .addr0 (cpu.addr[aw-1:0]),
        .data0 (cpu.wdata),
        .we0   (we_code),
        .q0    (code_cpu),
        .addr1 (rd_addr),
        .q1    (code)
    );

    dual_port_ram #(.aw(aw), .dw(8)) u_attr (
        .clk   (clk),
        .addr0 (cpu.addr[aw-1:0]),
        .data0 (cpu.wdata),
        .we0   (we_attr),
        .q0    (attr_cpu),
        .addr1 (rd_addr),
        .q1    (attr)
    );

    palette_prom u_palette (
        .clk     (clk),
        .cen     (pxl_cen),
        .wr_addr (prog_addr),
        .data    (prog_data),
        .we      (prog_en),
        .rd_addr (pal_addr),
        .q       (pxl)
    );

    // ROM address only moves on the fetch strobe
    a_rom_addr_hold: assert property (@(posedge clk) disable iff (rst)
        !(pxl_cen && heff[2:0] == 3'd0) |=> $stable(rom_addr));

endmodule

// File: source/video_timing.sv
// Video timing generator
// Pixel strobe from a clock divider, beam counters and horizontal blank

`timescale 1ns/10ps

module video_timing import tilemap_pkg::*; #(
    parameter int pxl_div = 8,
    parameter int h_total = 384,
    parameter int v_total = 264
)(
    input  logic  clk,
    input  logic  rst,
    output logic  pxl_cen,
    output beam_t beam
);

    localparam int dw = $clog2(pxl_div);

    logic [dw-1:0] div_cnt;
    logic [8:0]    hcnt;
    logic [8:0]    vcnt;    // Runs past 255 during vertical blank

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt <= '0;
            pxl_cen <= 1'b0;
        end else begin
            pxl_cen <= div_cnt == dw'(pxl_div - 1);
            div_cnt <= (div_cnt == dw'(pxl_div - 1)) ? '0 : div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hcnt <= '0;
            vcnt <= '0;
        end else if (pxl_cen) begin
            hcnt <= (hcnt == 9'(h_total - 1)) ? '0 : hcnt + 1'b1;
            // Row advances as the blank starts, fetches for the next line see it
            if (hcnt == 9'(h_active - 1)) begin
                vcnt <= (vcnt == 9'(v_total - 1)) ? '0 : vcnt + 1'b1;
            end
        end
    end

    assign beam.hdump = hcnt;
    assign beam.vdump = vcnt[7:0];
    assign beam.lhbl  = hcnt < 9'(h_active);

    a_cen_single: assert property (@(posedge clk) disable iff (rst)
        pxl_cen |=> !pxl_cen);

endmodule

// File: source/palette_prom.sv
// Palette PROM, 256 entries of 4 bits
// Loaded by strobe, read registered on the pixel strobe

`timescale 1ns/10ps

module palette_prom import tilemap_pkg::*; (
    input  logic           clk,
    input  logic           cen,
    input  logic [7:0]     wr_addr,
    input  logic [3:0]     data,
    input  logic           we,
    input  pal_prom_addr_t rd_addr,
    output logic [3:0]     q
);

    logic [3:0] mem [0:255];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= data;
        end
    end

    // Output only moves with the pixel clock enable
    always_ff @(posedge clk) begin
        if (cen) begin
            q <= mem[rd_addr];
        end
    end

endmodule

// File: source/dual_port_ram.sv
// Dual-port synchronous RAM
// Port 0 reads and writes, port 1 only reads, both reads registered

`timescale 1ns/10ps

module dual_port_ram #(
    parameter int aw = 11,
    parameter int dw = 8
)(
    input  logic          clk,
    // Port 0
    input  logic [aw-1:0] addr0,
    input  logic [dw-1:0] data0,
    input  logic          we0,
    output logic [dw-1:0] q0,
    // Port 1
    input  logic [aw-1:0] addr1,
    output logic [dw-1:0] q1
);

    logic [dw-1:0] mem [0:2**aw-1];

    always_ff @(posedge clk) begin
        if (we0) begin
            mem[addr0] <= data0;
        end
        q0 <= mem[addr0];   // Old data on a write cycle
    end

    always_ff @(posedge clk) begin
        q1 <= mem[addr1];
    end

endmodule

// File: common/tilemap_pkg.sv
// Shared definitions for the scrolling tile layer
// Geometry, CPU bus and beam position bundles, attribute decoding

package tilemap_pkg;

    localparam int vram_aw  = 11;   // Per bank, 32 rows of 64 tiles
    localparam int rom_aw   = 14;   // Graphics ROM word address
    localparam int h_active = 256;  // Visible pixels per line

    // One CPU access, bit 11 of addr picks the attribute bank
    typedef struct packed {
        logic [11:0] addr;
        logic [7:0]  wdata;
        logic        rnw;
        logic        cs;
    } cpu_bus_t;

    typedef struct packed {
        logic [8:0] hdump;
        logic [7:0] vdump;
        logic       lhbl;   // High while the line is visible
    } beam_t;

    typedef struct packed {
        logic       code_top;
        logic [1:0] code_hi;
        logic       hflip;
        logic [3:0] pal;
    } attr_normal_t;

    // Board jumper variant, only one extension bit reaches the ROM
    typedef struct packed {
        logic       code_top;
        logic       ext;
        logic       rsvd;
        logic       hflip;
        logic [3:0] pal;
    } attr_hyper_t;

    typedef union packed {
        attr_normal_t n;
        attr_hyper_t  h;
    } tile_attr_u;

    typedef struct packed {
        logic [3:0] pal;
        logic [3:0] pix;
    } pal_prom_addr_t;

endpackage
